/* rv32_isa_pkg.sv */
/*
    RV32I instruction-set definitions
    - Major opcodes of the supported groups
    - funct7 and funct3 values
    - Instruction word union with R, I and U format views
*/
package rv32_isa_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b01_100_11;   // R-type arithmetic
    localparam logic [6:0] OPC_OP_IMM = 7'b00_100_11;   // I-type arithmetic
    localparam logic [6:0] OPC_JAL    = 7'b11_011_11;
    localparam logic [6:0] OPC_JALR   = 7'b11_001_11;
    localparam logic [6:0] OPC_AUIPC  = 7'b00_101_11;

    // funct7 values
    localparam logic [6:0] F7_BASE = 7'b0_000_000;
    localparam logic [6:0] F7_ALT  = 7'b0_100_000;      // SUB, SRA, SRAI

    // funct3 values
    localparam logic [2:0] F3_ADD  = 3'b000;            // Also SUB, ADDI, JALR
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;            // SRL and SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // One 32-bit word, three field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;                                            // Register format
        struct packed {
            logic [11:0] imm;                           // Shamt in low 5 bits for shifts
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;                                            // Immediate format
        struct packed {
            logic [19:0] imm;                           // Upper 20 bits of the value
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;                                            // Upper-immediate format
    } instr_word_u;

endpackage

/* apx_cfg_pkg.sv */
/*
    Execute stage configuration
    - ALU operation codes passed from stage 1 to stage 2
    - Accuracy level width and saturation limit
    - Control register address map
*/
package apx_cfg_pkg;

    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD     = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_APX_ADD = 4'd1;  // Lower-part-OR adder
    localparam logic [ALU_OP_W-1:0] ALU_SUB     = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLL     = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLT     = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU    = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_XOR     = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRL     = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SRA     = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_OR      = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_AND     = 4'd10;

    localparam int ACC_W   = 8;                          // Accuracy level width
    localparam int ACC_MAX = 16;                         // Saturation value

    localparam int                   CSR_ADR_W    = 4;   // Word address width
    localparam logic [CSR_ADR_W-1:0] CSR_ACCURACY = 4'd0;

endpackage

/* approx_adder.sv */
/*
    Lower-part-OR approximate adder
    - Low k bits are the OR of the operands
    - Upper bits are an exact sum with no carry from below
*/
`timescale 1ns/1ns

module approx_adder
(
    input  logic [31:0]                   input_1,
    input  logic [31:0]                   input_2,
    input  logic [apx_cfg_pkg::ACC_W-1:0] accuracy,   // OR part width, exact at 0
    output logic [31:0]                   result
);
    logic [31:0] low_mask;                            // Ones over the approximate part
    logic [31:0] low_part;
    logic [31:0] high_sum;

    assign low_mask = (32'd1 << accuracy) - 32'd1;    // All ones from 32 up
    assign low_part = (input_1 | input_2) & low_mask;
    assign high_sum = (input_1 & ~low_mask) + (input_2 & ~low_mask);  // Carry cut at boundary
    assign result   = high_sum | low_part;

endmodule

/* instruction_decoder.sv */
/*
    Execute stage 1
    - I and U immediate generation
    - Opcode, funct3 and funct7 mapping to an ALU code or illegal
    - Operand selection and stage 1 registers
*/
`timescale 1ns/1ns

module instruction_decoder #(parameter APPROXIMATE = 0)
(
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             issue_valid,     // Instruction taken this edge
    input  logic [31:0]                      instr,
    input  logic [31:0]                      pc,
    input  logic [31:0]                      rs1_data,
    input  logic [31:0]                      rs2_data,
    input  logic [apx_cfg_pkg::ACC_W-1:0]    accuracy_level,  // From control register
    output logic                             dec_valid,
    output logic [apx_cfg_pkg::ALU_OP_W-1:0] dec_op,
    output logic                             dec_illegal,
    output logic [31:0]                      operand_1,
    output logic [31:0]                      operand_2,
    output logic [apx_cfg_pkg::ACC_W-1:0]    dec_accuracy     // Level sampled at issue
);
    import rv32_isa_pkg::*;
    import apx_cfg_pkg::*;

    instr_word_u         iw;
    logic [31:0]         imm_i;
    logic [31:0]         imm_u;
    logic                alt;                                 // funct7 selects SUB or SRA
    logic [ALU_OP_W-1:0] op_next;
    logic                illegal_next;
    logic [31:0]         opnd_1_next;
    logic [31:0]         opnd_2_next;

    // funct3 to ALU code, shared by OP and OP_IMM
    function automatic logic [ALU_OP_W-1:0] funct_op(input logic [2:0] funct3,
                                                      input logic       use_alt);
        logic [ALU_OP_W-1:0] code;
        case (funct3)
            F3_ADD:  code = use_alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  code = ALU_SLL;
            F3_SLT:  code = ALU_SLT;
            F3_SLTU: code = ALU_SLTU;
            F3_XOR:  code = ALU_XOR;
            F3_SR:   code = use_alt ? ALU_SRA : ALU_SRL;
            F3_OR:   code = ALU_OR;
            default: code = ALU_AND;                          // F3_AND
        endcase
        return code;
    endfunction

    assign iw    = instr;
    assign imm_i = {{20{iw.i.imm[11]}}, iw.i.imm};            // Sign extended
    assign imm_u = {iw.u.imm, 12'b0};
    assign alt   = (iw.r.funct7 == F7_ALT);

    always_comb
    begin
        op_next      = funct_op(iw.r.funct3, alt);
        illegal_next = 1'b0;
        opnd_1_next  = rs1_data;                              // Register sources by default
        opnd_2_next  = rs2_data;
        case (iw.r.opcode)
            OPC_OP:
            begin
                if (iw.r.funct7 != F7_BASE &&
                    !(alt && (iw.r.funct3 == F3_ADD || iw.r.funct3 == F3_SR)))
                    illegal_next = 1'b1;
                else if (iw.r.funct3 == F3_ADD && !alt && APPROXIMATE == 1)
                    op_next = ALU_APX_ADD;                    // Only R-type ADD is approximate
            end
            OPC_OP_IMM:
            begin
                opnd_2_next = imm_i;
                op_next     = funct_op(iw.i.funct3, alt && iw.i.funct3 == F3_SR);
                if (iw.i.funct3 == F3_SLL && iw.r.funct7 != F7_BASE)
                    illegal_next = 1'b1;
                if (iw.i.funct3 == F3_SR && iw.r.funct7 != F7_BASE && !alt)
                    illegal_next = 1'b1;
            end
            OPC_JAL, OPC_JALR:
            begin
                op_next     = ALU_ADD;                        // Link value PC+4
                opnd_1_next = pc;
                opnd_2_next = 32'd4;
                if (iw.r.opcode == OPC_JALR && iw.i.funct3 != F3_ADD)
                    illegal_next = 1'b1;
            end
            OPC_AUIPC:
            begin
                op_next     = ALU_ADD;
                opnd_1_next = pc;
                opnd_2_next = imm_u;
            end
            default: illegal_next = 1'b1;                     // Unsupported opcode
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            dec_valid <= 1'b0;
        else
            dec_valid <= issue_valid;
    end

    // Stage 1 payload
    always_ff @(posedge clk)
    begin
        dec_op       <= op_next;
        dec_illegal  <= illegal_next;
        operand_1    <= opnd_1_next;
        operand_2    <= opnd_2_next;
        dec_accuracy <= accuracy_level;
    end

endmodule

/* arithmetic_logic_unit.sv */
/*
    Execute stage 2
    - Operation code execution with the approximate adder for ALU_APX_ADD
    - Zero result on illegal instructions
    - Stage 2 result registers
*/
`timescale 1ns/1ns

module arithmetic_logic_unit
(
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             dec_valid,
    input  logic [apx_cfg_pkg::ALU_OP_W-1:0] dec_op,
    input  logic                             dec_illegal,
    input  logic [31:0]                      operand_1,
    input  logic [31:0]                      operand_2,
    input  logic [apx_cfg_pkg::ACC_W-1:0]    dec_accuracy,
    output logic                             result_valid,
    output logic [31:0]                      result,
    output logic                             illegal
);
    import apx_cfg_pkg::*;

    logic [31:0] apx_sum;                               // Approximate adder output
    logic [31:0] alu_out;
    logic [4:0]  shamt;

    assign shamt = operand_2[4:0];                      // Shifts use low 5 bits

    approx_adder apx_add0
    (
        .input_1  (operand_1),
        .input_2  (operand_2),
        .accuracy (dec_accuracy),
        .result   (apx_sum)
    );

    always_comb
    begin
        case (dec_op)
            ALU_ADD:     alu_out = operand_1 + operand_2;
            ALU_APX_ADD: alu_out = apx_sum;
            ALU_SUB:     alu_out = operand_1 - operand_2;
            ALU_SLL:     alu_out = operand_1 << shamt;
            ALU_SLT:     alu_out = {31'b0, $signed(operand_1) < $signed(operand_2)};
            ALU_SLTU:    alu_out = {31'b0, operand_1 < operand_2};
            ALU_XOR:     alu_out = operand_1 ^ operand_2;
            ALU_SRL:     alu_out = operand_1 >> shamt;
            ALU_SRA:     alu_out = $unsigned($signed(operand_1) >>> shamt);  // Sign fill
            ALU_OR:      alu_out = operand_1 | operand_2;
            ALU_AND:     alu_out = operand_1 & operand_2;
            default:     alu_out = 32'b0;               // Unused codes
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            result_valid <= 1'b0;
            illegal      <= 1'b0;
        end
        else
        begin
            result_valid <= dec_valid;
            illegal      <= dec_valid && dec_illegal;  // Flag only on a real result
        end
    end

    // Result payload, forced to 0 when illegal
    always_ff @(posedge clk)
    begin
        result <= dec_illegal ? 32'b0 : alu_out;
    end

endmodule

/* accuracy_csr.sv */
/*
    Accuracy control register
    - Wishbone classic slave with a one-cycle ack pulse
    - Saturating write of the accuracy level, zero-extended read
*/
`timescale 1ns/1ns

module accuracy_csr
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  logic [apx_cfg_pkg::CSR_ADR_W-1:0]  wb_adr,      // Word address
    input  logic [31:0]                        wb_dat_w,
    output logic                               wb_ack,
    output logic [31:0]                        wb_dat_r,
    output logic [apx_cfg_pkg::ACC_W-1:0]      accuracy_level
);
    import apx_cfg_pkg::*;

    logic             req;                                  // New bus request
    logic             hit;                                  // Accuracy register addressed
    logic [ACC_W-1:0] wr_level;                             // Saturated write value

    assign req      = wb_cyc && wb_stb && !wb_ack;          // Ack low so one pulse per access
    assign hit      = (wb_adr == CSR_ACCURACY);
    assign wr_level = (wb_dat_w[ACC_W-1:0] > ACC_W'(ACC_MAX)) ? ACC_W'(ACC_MAX)
                                                              : wb_dat_w[ACC_W-1:0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_ack         <= 1'b0;
            accuracy_level <= '0;                           // Exact after reset
        end
        else
        begin
            wb_ack <= req;
            if (req && wb_we && hit)
                accuracy_level <= wr_level;                 // Visible with the ack
        end
    end

    // Read data, valid while ack is high
    always_ff @(posedge clk)
    begin
        if (req)
            wb_dat_r <= (!wb_we && hit) ? {{(32-ACC_W){1'b0}}, accuracy_level} : 32'b0;
    end

endmodule

/* execute_stage.sv */
/*
    RV32I execute stage top level
    - Decoder, ALU and accuracy register
    - Two-cycle issue to result pipeline
*/
`timescale 1ns/1ns

module execute_stage #(parameter APPROXIMATE = 1)
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              issue_valid,
    input  logic [31:0]                       instr,
    input  logic [31:0]                       pc,
    input  logic [31:0]                       rs1_data,
    input  logic [31:0]                       rs2_data,
    output logic                              result_valid,
    output logic [31:0]                       result,
    output logic                              illegal,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [apx_cfg_pkg::CSR_ADR_W-1:0] wb_adr,
    input  logic [31:0]                       wb_dat_w,
    output logic                              wb_ack,
    output logic [31:0]                       wb_dat_r
);
    import apx_cfg_pkg::*;

    logic                dec_valid;                 // Stage 1 to stage 2
    logic [ALU_OP_W-1:0] dec_op;
    logic                dec_illegal;
    logic [31:0]         operand_1;
    logic [31:0]         operand_2;
    logic [ACC_W-1:0]    dec_accuracy;
    logic [ACC_W-1:0]    accuracy_level;            // Control register to decoder

    instruction_decoder #(.APPROXIMATE(APPROXIMATE)) dec0
    (
        .clk, .reset, .issue_valid, .instr, .pc, .rs1_data, .rs2_data, .accuracy_level,
        .dec_valid, .dec_op, .dec_illegal, .operand_1, .operand_2, .dec_accuracy
    );

    arithmetic_logic_unit alu0
    (
        .clk, .reset, .dec_valid, .dec_op, .dec_illegal, .operand_1, .operand_2,
        .dec_accuracy, .result_valid, .result, .illegal
    );

    accuracy_csr csr0
    (
        .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .wb_ack, .wb_dat_r, .accuracy_level
    );

endmodule

/* execute_stage_asserts.sv */
/*
    Bound assertions for the execute stage
    - Two-cycle issue to result latency
    - Wishbone ack only after a request
    - Zero result on illegal instructions
*/
`timescale 1ns/1ns

module execute_stage_asserts
(
    input logic        clk,
    input logic        reset,
    input logic        issue_valid,
    input logic        result_valid,
    input logic [31:0] result,
    input logic        illegal,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_ack
);
    int fail_count = 0;

    result_latency: assert property (@(posedge clk) disable iff (reset)
                                     result_valid == $past(issue_valid, 2))
    else
    begin
        fail_count++;
        $error("result_valid does not follow issue_valid by 2 cycles");
    end

    ack_after_request: assert property (@(posedge clk) disable iff (reset)
                                        wb_ack |-> $past(wb_cyc && wb_stb))
    else
    begin
        fail_count++;
        $error("wb_ack without wb_cyc and wb_stb in the previous cycle");
    end

    illegal_zero: assert property (@(posedge clk) disable iff (reset)
                                   illegal |-> result == 32'b0)
    else
    begin
        fail_count++;
        $error("illegal instruction with a nonzero result");
    end

endmodule

bind execute_stage execute_stage_asserts asrt0
(
    .clk          (clk),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .result_valid (result_valid),
    .result       (result),
    .illegal      (illegal),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_ack       (wb_ack)
);

/* tb_execute_stage.sv */
/*
    Testbench for the RV32I execute stage
    - Clock, reset, LCG stimulus and Wishbone bus tasks
    - Reference model with a queue of expected results
    - Five random tests, per-test report lines and a cycle limit
*/
`timescale 1ns/1ns

module tb_execute_stage;
    import rv32_isa_pkg::*;
    import apx_cfg_pkg::*;

    localparam int T1_LEN      = 50;                    // Cycle budget of each test
    localparam int T2_LEN      = 30;
    localparam int T3_LEN      = 90;
    localparam int T4_LEN      = 130;
    localparam int T5_LEN      = 140;
    localparam int CYCLE_LIMIT = 3 + T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN + 200;

    logic                 clk;
    logic                 reset;
    logic                 issue_valid;
    logic [31:0]          instr;
    logic [31:0]          pc;
    logic [31:0]          rs1_data;
    logic [31:0]          rs2_data;
    logic                 result_valid;
    logic [31:0]          result;
    logic                 illegal;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [CSR_ADR_W-1:0] wb_adr;
    logic [31:0]          wb_dat_w;
    logic                 wb_ack;
    logic [31:0]          wb_dat_r;

    logic [31:0] seed = 32'h989a81fe;
    logic [7:0]  cur_level = 8'd0;                      // Level the model expects
    logic [32:0] exp_q[$];                              // {illegal, result} in issue order
    string       cur_test = "reset";
    int          err_count = 0;
    int          check_count = 0;
    int          t_errs;
    int          t_checks;
    int          cycles = 0;
    logic [31:0] w;
    logic [31:0] r;
    logic [31:0] rd_data;

    execute_stage #(.APPROXIMATE(1)) dut0
    (
        .clk, .reset, .issue_valid, .instr, .pc, .rs1_data, .rs2_data,
        .result_valid, .result, .illegal,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_ack, .wb_dat_r
    );

    always #2 clk = ~clk;                               // 4 ns period

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Integer group semantics by funct3
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] y;
        case (f3)
            F3_ADD:  y = alt ? a - b : a + b;
            F3_SLL:  y = a << b[4:0];
            F3_SLT:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: y = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  y = a ^ b;
            F3_SR:
            begin
                if (alt)
                    y = $unsigned($signed(a) >>> b[4:0]);   // Sign fill
                else
                    y = a >> b[4:0];
            end
            F3_OR:   y = a | b;
            default: y = a & b;
        endcase
        return y;
    endfunction

    // Expected {illegal, result} of one instruction
    function automatic logic [32:0] model_exec(input logic [31:0] iw, input logic [31:0] pc_v,
                                               input logic [31:0] a, input logic [31:0] b,
                                               input logic [7:0] k);
        logic [31:0] imm;
        logic [31:0] low;
        logic [31:0] y;
        logic        bad;
        imm = {{20{iw[31]}}, iw[31:20]};
        bad = 1'b0;
        y   = 32'b0;
        case (iw[6:0])
            OPC_OP:
            begin
                bad = (iw[31:25] != F7_BASE) &&
                      !(iw[31:25] == F7_ALT && (iw[14:12] == F3_ADD || iw[14:12] == F3_SR));
                if (iw[14:12] == F3_ADD && iw[31:25] == F7_BASE)
                begin
                    low = (a | b) & ~(32'hFFFF_FFFF << k);  // OR over the low k bits
                    y   = (((a >> k) + (b >> k)) << k) | low;
                end
                else
                    y = alu_ref(iw[14:12], iw[31:25] == F7_ALT, a, b);
            end
            OPC_OP_IMM:
            begin
                if (iw[14:12] == F3_SLL)
                    bad = (iw[31:25] != F7_BASE);
                else if (iw[14:12] == F3_SR)
                    bad = (iw[31:25] != F7_BASE && iw[31:25] != F7_ALT);
                y = alu_ref(iw[14:12], iw[14:12] == F3_SR && iw[31:25] == F7_ALT, a, imm);
            end
            OPC_JAL:   y = pc_v + 32'd4;                    // Link value
            OPC_JALR:
            begin
                bad = (iw[14:12] != 3'd0);
                y   = pc_v + 32'd4;
            end
            OPC_AUIPC: y = pc_v + {iw[31:12], 12'b0};
            default:   bad = 1'b1;
        endcase
        return bad ? {1'b1, 32'b0} : {1'b0, y};
    endfunction

    // Legal OP or OP_IMM word with random fields
    function automatic logic [31:0] alu_word();
        logic [31:0] iw;
        logic [31:0] sel;
        iw  = lcg_next();
        sel = lcg_next();
        iw[14:12] = sel[2:0];
        if (sel[3])
        begin
            iw[6:0]   = OPC_OP;
            iw[31:25] = (sel[4] && (sel[2:0] == F3_ADD || sel[2:0] == F3_SR)) ? F7_ALT : F7_BASE;
        end
        else
        begin
            iw[6:0] = OPC_OP_IMM;
            if (sel[2:0] == F3_SLL || sel[2:0] == F3_SR)
                iw[31:25] = (sel[4] && sel[2:0] == F3_SR) ? F7_ALT : F7_BASE;
        end
        return iw;
    endfunction

    task automatic check(input string name, input logic [32:0] expected,
                         input logic [32:0] actual);
        check_count++;
        if (expected !== actual)
        begin
            err_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic issue_instr(input logic [31:0] iw);
        logic [31:0] pc_v;
        logic [31:0] a;
        logic [31:0] b;
        pc_v = lcg_next() & 32'hFFFF_FFFC;                  // Word aligned
        a    = lcg_next();
        b    = lcg_next();
        @(posedge clk);
        #1;
        issue_valid = 1'b1;
        instr       = iw;
        pc          = pc_v;
        rs1_data    = a;
        rs2_data    = b;
        exp_q.push_back(model_exec(iw, pc_v, a, b, cur_level));
    endtask

    task automatic pause(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
            issue_valid = 1'b0;
        end
    endtask

    // Ack wait shared by reads and writes, then drop the strobe
    task automatic wait_ack(output logic [31:0] data);
        int n;
        n = 0;
        @(negedge clk);
        while (!wb_ack && n < 16)
        begin
            n++;
            @(negedge clk);
        end
        if (!wb_ack)
        begin
            err_count++;
            $display("%s: bus access got no acknowledge within 16 cycles", cur_test);
        end
        data = wb_dat_r;
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [CSR_ADR_W-1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        wait_ack(unused);
        if (adr == CSR_ACCURACY)
            cur_level = (data[7:0] > 8'd16) ? 8'd16 : data[7:0];   // Low byte, capped at 16
    endtask

    task automatic bus_read(input logic [CSR_ADR_W-1:0] adr, output logic [31:0] data);
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack(data);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        t_checks = check_count;
        t_errs   = err_count;
    endtask

    task automatic end_test();
        pause(1);
        while (exp_q.size() != 0)                           // Drain the pipeline
            @(negedge clk);
        $display("%s finished: %0d checks, %0d errors", cur_test,
                 check_count - t_checks, err_count - t_errs);
    endtask

    // Result monitor, sampled away from the active edge
    always @(negedge clk)
    begin
        if (!reset && result_valid)
        begin
            if (exp_q.size() == 0)
            begin
                err_count++;
                $display("%s: result_valid high with no instruction outstanding", cur_test);
            end
            else
                check(cur_test, exp_q.pop_front(), {illegal, result});
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial
    begin
        clk         = 1'b0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        instr       = 32'b0;
        pc          = 32'b0;
        rs1_data    = 32'b0;
        rs2_data    = 32'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = 32'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test("alu_back_to_back");                     // Level 0, exact
        repeat (40) issue_instr(alu_word());
        end_test();

        start_test("jump_link_auipc");
        repeat (16)
        begin
            w = lcg_next();
            r = lcg_next();
            case (r[1:0])
                2'd0:    w[6:0] = OPC_JAL;
                2'd1:    w[6:0] = OPC_AUIPC;
                default:
                begin
                    w[6:0]   = OPC_JALR;
                    w[14:12] = (r[3:2] == 2'd0) ? {r[6:5], 1'b1} : F3_ADD;
                end
            endcase
            issue_instr(w);
        end
        w = lcg_next();
        w[6:0]   = OPC_JALR;
        w[14:12] = 3'd2;                                    // Always illegal
        issue_instr(w);
        end_test();

        start_test("csr_access");
        repeat (8)
        begin
            r = lcg_next();
            if (r[31])
                r[7:0] = r[7:0] % 8'd17;                    // Within range
            bus_write(CSR_ACCURACY, r);
            bus_read(CSR_ACCURACY, rd_data);
            check(cur_test, {25'b0, cur_level}, {1'b0, rd_data});
            r = lcg_next();
            bus_read((r[3:0] == 4'd0) ? 4'd1 : r[3:0], rd_data);   // Unmapped address
            check(cur_test, 33'b0, {1'b0, rd_data});
        end
        end_test();

        start_test("approx_add");
        repeat (6)
        begin
            r = lcg_next();
            bus_write(CSR_ACCURACY, {24'b0, r[7:0] % 8'd21});
            repeat (6)
            begin
                w = lcg_next();
                w[6:0]   = OPC_OP;
                w[14:12] = F3_ADD;
                w[31:25] = F7_BASE;
                issue_instr(w);
                w[6:0] = OPC_OP_IMM;                        // ADDI stays exact
                issue_instr(w);
            end
            pause(1);
        end
        end_test();

        start_test("illegal_and_gaps");
        repeat (30)
        begin
            w = lcg_next();
            r = lcg_next();
            case (r[1:0])
                2'd0: w[6:0] = OPC_OP;                      // Random funct7
                2'd1:
                begin
                    w[6:0]   = OPC_OP_IMM;
                    w[14:12] = r[2] ? F3_SR : F3_SLL;
                end
                2'd2: w = alu_word();
                default: w = w;                             // Any opcode
            endcase
            issue_instr(w);
            pause(r[5:4]);
        end
        end_test();

        err_count += dut0.asrt0.fail_count;
        $display("Total: %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* src.f */
rv32_isa_pkg.sv
apx_cfg_pkg.sv
approx_adder.sv
instruction_decoder.sv
arithmetic_logic_unit.sv
accuracy_csr.sv
execute_stage.sv
execute_stage_asserts.sv
tb_execute_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_execute_stage -f src.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    exit 1
fi
exit 0
